// ==== debug_cpu.f ====
design/debug_cpu_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/debug_unit.sv
design/instr_mem.sv
design/cpu_core.sv
design/debug_cpu_top.sv
verification/debug_cpu_properties.sv
verification/debug_cpu_tb.sv

// ==== design/cpu_core.sv ====
`default_nettype none

module cpu_core (
    input  wire                               i_clock,
    input  wire                               i_rst,
    input  wire                               i_step,
    input  wire  debug_cpu_pkg::instr_t       i_instr,
    input  wire  [debug_cpu_pkg::REG_AW-1:0]  i_dump_reg,
    output logic                              o_halted,
    output logic [debug_cpu_pkg::WORD_W-1:0]  o_pc,
    output logic [debug_cpu_pkg::WORD_W-1:0]  o_dump_data
);

    logic [debug_cpu_pkg::WORD_W-1:0] regs [debug_cpu_pkg::NUM_REGS];
    logic [debug_cpu_pkg::WORD_W-1:0] dmem [debug_cpu_pkg::MEM_WORDS];

    logic                             exec;
    logic [debug_cpu_pkg::WORD_W-1:0] rs_val;
    logic [debug_cpu_pkg::WORD_W-1:0] rt_val;
    logic [debug_cpu_pkg::WORD_W-1:0] store_val;
    logic [debug_cpu_pkg::WORD_W-1:0] imm_ext;
    logic [debug_cpu_pkg::WORD_W-1:0] addr_sum;
    logic [debug_cpu_pkg::MEM_AW-1:0] dm_idx;
    logic                             wr_en;
    logic [debug_cpu_pkg::REG_AW-1:0] wr_idx;
    logic [debug_cpu_pkg::WORD_W-1:0] wr_val;
    logic                             dm_we;
    logic                             is_halt;

    assign exec = i_step && !o_halted;

    assign rs_val    = regs[i_instr.r.rs];
    assign rt_val    = regs[i_instr.r.rt];
    assign store_val = regs[i_instr.i.rt];
    assign imm_ext   = {{16{i_instr.i.imm[15]}}, i_instr.i.imm};
    assign addr_sum  = rs_val + imm_ext;
    assign dm_idx    = addr_sum[debug_cpu_pkg::MEM_AW-1:0];  // Wraps in the 16 words

    always_comb begin
        wr_en   = 1'b0;
        wr_idx  = i_instr.i.rt;
        wr_val  = addr_sum;
        dm_we   = 1'b0;
        is_halt = 1'b0;
        case (i_instr.r.opcode)
            debug_cpu_pkg::OP_ADD: begin
                wr_en  = 1'b1;
                wr_idx = i_instr.r.rd;
                wr_val = rs_val + rt_val;
            end
            debug_cpu_pkg::OP_SUB: begin
                wr_en  = 1'b1;
                wr_idx = i_instr.r.rd;
                wr_val = rs_val - rt_val;
            end
            debug_cpu_pkg::OP_ADDI: wr_en = 1'b1;
            debug_cpu_pkg::OP_LW: begin
                wr_en  = 1'b1;
                wr_val = dmem[dm_idx];
            end
            debug_cpu_pkg::OP_SW: dm_we = 1'b1;
            default: is_halt = 1'b1;    // HALT and unused codes
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_pc     <= '0;
            o_halted <= 1'b0;
            for (int k = 0; k < debug_cpu_pkg::NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (exec) begin
            if (is_halt) o_halted <= 1'b1;   // PC stays on the HALT word
            else o_pc <= o_pc + 1'b1;
            if (wr_en && wr_idx != '0) regs[wr_idx] <= wr_val;
        end
    end

    always_ff @(posedge i_clock) begin
        if (exec && dm_we) dmem[dm_idx] <= store_val;
    end

    assign o_dump_data = regs[i_dump_reg];

endmodule

`default_nettype wire

// ==== design/debug_cpu_pkg.sv ====
`default_nettype none

package debug_cpu_pkg;

    localparam int WORD_W       = 32;
    localparam int BYTE_W       = 8;
    localparam int NUM_REGS     = 8;
    localparam int REG_AW       = 3;
    localparam int MEM_WORDS    = 16;
    localparam int MEM_AW       = 4;
    localparam int CLKS_PER_BIT = 16;   // Simulation rate, raise for hardware

    // Opcodes, anything above OP_SW behaves as HALT
    localparam logic [3:0] OP_HALT = 4'd0;
    localparam logic [3:0] OP_ADD  = 4'd1;
    localparam logic [3:0] OP_SUB  = 4'd2;
    localparam logic [3:0] OP_ADDI = 4'd3;
    localparam logic [3:0] OP_LW   = 4'd4;
    localparam logic [3:0] OP_SW   = 4'd5;

    localparam logic [BYTE_W-1:0] CMD_WRITE = 8'h57;  // 'W'
    localparam logic [BYTE_W-1:0] CMD_RUN   = 8'h52;  // 'R'
    localparam logic [BYTE_W-1:0] CMD_STEP  = 8'h53;  // 'S'

    typedef union packed {
        struct packed {
            logic [3:0]        opcode;
            logic [REG_AW-1:0] rd;
            logic [REG_AW-1:0] rs;
            logic [REG_AW-1:0] rt;
            logic [18:0]       unused;
        } r;
        struct packed {
            logic [3:0]        opcode;
            logic [REG_AW-1:0] rt;
            logic [REG_AW-1:0] rs;
            logic [5:0]        unused;
            logic [15:0]       imm;
        } i;
    } instr_t;

endpackage

`default_nettype wire

// ==== design/debug_cpu_top.sv ====
`default_nettype none

module debug_cpu_top (
    input  wire   i_clock,
    input  wire   i_rst,
    input  wire   i_rx,
    output logic  o_tx,
    output logic  o_halted,
    output logic  o_busy
);

    logic [debug_cpu_pkg::BYTE_W-1:0] rx_data;
    logic                             rx_done;
    logic [debug_cpu_pkg::BYTE_W-1:0] tx_data;
    logic                             tx_start;
    logic                             tx_done;
    logic                             im_we;
    logic [debug_cpu_pkg::MEM_AW-1:0] im_addr;
    logic [1:0]                       im_byte_sel;
    debug_cpu_pkg::instr_t            instr;
    logic                             cpu_step;
    logic [debug_cpu_pkg::WORD_W-1:0] pc;
    logic [debug_cpu_pkg::REG_AW-1:0] dump_reg;
    logic [debug_cpu_pkg::WORD_W-1:0] dump_data;

    uart_rx uart_rx_1 (.i_clock(i_clock), .i_rst(i_rst), .i_rx(i_rx),
                       .o_data(rx_data), .o_done(rx_done));

    uart_tx uart_tx_1 (.i_clock(i_clock), .i_rst(i_rst), .i_start(tx_start),
                       .i_data(tx_data), .o_tx(o_tx), .o_done(tx_done));

    debug_unit debug_unit_1 (.i_clock(i_clock), .i_rst(i_rst),
                             .i_rx_done(rx_done), .i_tx_done(tx_done),
                             .i_halted(o_halted), .i_rx_data(rx_data),
                             .i_pc(pc), .i_dump_data(dump_data),
                             .o_tx_start(tx_start), .o_im_we(im_we),
                             .o_cpu_step(cpu_step), .o_busy(o_busy),
                             .o_tx_data(tx_data), .o_im_addr(im_addr),
                             .o_im_byte_sel(im_byte_sel), .o_dump_reg(dump_reg));

    instr_mem instr_mem_1 (.i_clock(i_clock), .i_we(im_we), .i_addr(im_addr),
                           .i_fetch_addr(pc[debug_cpu_pkg::MEM_AW-1:0]), // PC low bits
                           .i_byte_sel(im_byte_sel), .i_byte(rx_data), .o_instr(instr));

    cpu_core cpu_core_1 (.i_clock(i_clock), .i_rst(i_rst), .i_step(cpu_step),
                         .i_instr(instr), .i_dump_reg(dump_reg),
                         .o_halted(o_halted), .o_pc(pc), .o_dump_data(dump_data));

endmodule

`default_nettype wire

// ==== design/debug_unit.sv ====
`default_nettype none

module debug_unit (
    input  wire                               i_clock,
    input  wire                               i_rst,
    input  wire                               i_rx_done,
    input  wire                               i_tx_done,
    input  wire                               i_halted,
    input  wire  [debug_cpu_pkg::BYTE_W-1:0]  i_rx_data,
    input  wire  [debug_cpu_pkg::WORD_W-1:0]  i_pc,
    input  wire  [debug_cpu_pkg::WORD_W-1:0]  i_dump_data,
    output logic                              o_tx_start,
    output logic                              o_im_we,
    output logic                              o_cpu_step,
    output logic                              o_busy,
    output logic [debug_cpu_pkg::BYTE_W-1:0]  o_tx_data,
    output logic [debug_cpu_pkg::MEM_AW-1:0]  o_im_addr,
    output logic [1:0]                        o_im_byte_sel,
    output logic [debug_cpu_pkg::REG_AW-1:0]  o_dump_reg
);

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_ADDR  = 3'd1;
    localparam logic [2:0] S_WBYTE = 3'd2;
    localparam logic [2:0] S_RUN   = 3'd3;
    localparam logic [2:0] S_STEP  = 3'd4;
    localparam logic [2:0] S_DSEND = 3'd5;
    localparam logic [2:0] S_DWAIT = 3'd6;

    logic [2:0]                       state;
    logic [1:0]                       byte_sel;
    logic [debug_cpu_pkg::REG_AW-1:0] dump_idx;   // 0 is the PC, then r1 to r7
    logic [1:0]                       dump_byte;
    logic [debug_cpu_pkg::WORD_W-1:0] dump_word;

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state     <= S_IDLE;
            byte_sel  <= '0;
            dump_idx  <= '0;
            dump_byte <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    dump_idx  <= '0;
                    dump_byte <= '0;
                    if (i_rx_done) begin
                        case (i_rx_data)
                            debug_cpu_pkg::CMD_WRITE: state <= S_ADDR;
                            debug_cpu_pkg::CMD_RUN:   state <= S_RUN;
                            debug_cpu_pkg::CMD_STEP:  state <= S_STEP;
                            default:                  state <= S_IDLE;
                        endcase
                    end
                end
                S_ADDR: begin
                    if (i_rx_done) begin
                        byte_sel <= '0;
                        state    <= S_WBYTE;
                    end
                end
                S_WBYTE: begin
                    if (i_rx_done) begin
                        byte_sel <= byte_sel + 1'b1;
                        if (byte_sel == 2'd3) state <= S_IDLE;
                    end
                end
                S_RUN: begin
                    if (i_halted) state <= S_DSEND;
                end
                S_STEP:  state <= S_DSEND;   // Single enable cycle
                S_DSEND: state <= S_DWAIT;
                S_DWAIT: begin
                    if (i_tx_done) begin
                        if (dump_idx == debug_cpu_pkg::NUM_REGS - 1 && dump_byte == 2'd3) begin
                            state <= S_IDLE;
                        end else begin
                            dump_byte <= dump_byte + 1'b1;
                            if (dump_byte == 2'd3) dump_idx <= dump_idx + 1'b1;
                            state <= S_DSEND;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == S_ADDR && i_rx_done) begin
            o_im_addr <= i_rx_data[debug_cpu_pkg::MEM_AW-1:0];
        end
    end

    assign dump_word  = (dump_idx == '0) ? i_pc : i_dump_data;
    assign o_tx_data  = dump_word[dump_byte*debug_cpu_pkg::BYTE_W +: debug_cpu_pkg::BYTE_W];
    assign o_dump_reg = dump_idx;
    assign o_tx_start = (state == S_DSEND);

    // Byte goes straight from the receiver into its lane
    assign o_im_we       = (state == S_WBYTE) && i_rx_done;
    assign o_im_byte_sel = byte_sel;

    assign o_cpu_step = (state == S_RUN) || (state == S_STEP);
    assign o_busy     = (state != S_IDLE);

endmodule

`default_nettype wire

// ==== design/instr_mem.sv ====
`default_nettype none

module instr_mem (
    input  wire                               i_clock,
    input  wire                               i_we,
    input  wire  [debug_cpu_pkg::MEM_AW-1:0]  i_addr,
    input  wire  [debug_cpu_pkg::MEM_AW-1:0]  i_fetch_addr,
    input  wire  [1:0]                        i_byte_sel,
    input  wire  [debug_cpu_pkg::BYTE_W-1:0]  i_byte,
    output debug_cpu_pkg::instr_t             o_instr
);

    logic [debug_cpu_pkg::WORD_W-1:0] mem [debug_cpu_pkg::MEM_WORDS];

    // One lane per write, lane 0 is the LSB
    always_ff @(posedge i_clock) begin
        if (i_we) begin
            mem[i_addr][i_byte_sel*debug_cpu_pkg::BYTE_W +: debug_cpu_pkg::BYTE_W] <= i_byte;
        end
    end

    assign o_instr = mem[i_fetch_addr];

endmodule

`default_nettype wire

// ==== design/uart_rx.sv ====
`default_nettype none

module uart_rx (
    input  wire                               i_clock,
    input  wire                               i_rst,
    input  wire                               i_rx,
    output logic [debug_cpu_pkg::BYTE_W-1:0]  o_data,
    output logic                              o_done
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic [1:0] state;
    logic       rx_meta;
    logic       rx_sync;
    logic [2:0] bit_cnt;
    logic [$clog2(debug_cpu_pkg::CLKS_PER_BIT)-1:0] tick_cnt;

    // Line idles high
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state    <= S_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    tick_cnt <= '0;
                    if (!rx_sync) state <= S_START;
                end
                S_START: begin
                    if (tick_cnt == debug_cpu_pkg::CLKS_PER_BIT / 2 - 1) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_sync ? S_IDLE : S_DATA;  // Glitch check
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (tick_cnt == debug_cpu_pkg::CLKS_PER_BIT - 1) begin
                        tick_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= S_STOP;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: begin
                    if (tick_cnt == debug_cpu_pkg::CLKS_PER_BIT - 1) begin
                        state  <= S_IDLE;
                        o_done <= rx_sync;  // Framing error gives no tick
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge i_clock) begin
        if (state == S_DATA && tick_cnt == debug_cpu_pkg::CLKS_PER_BIT - 1) begin
            o_data <= {rx_sync, o_data[debug_cpu_pkg::BYTE_W-1:1]};
        end
    end

endmodule

`default_nettype wire

// ==== design/uart_tx.sv ====
`default_nettype none

module uart_tx (
    input  wire                               i_clock,
    input  wire                               i_rst,
    input  wire                               i_start,
    input  wire  [debug_cpu_pkg::BYTE_W-1:0]  i_data,
    output logic                              o_tx,
    output logic                              o_done
);

    logic [debug_cpu_pkg::BYTE_W+1:0] shift;  // Stop, data, start
    logic                             busy;
    logic [3:0]                       bit_cnt;
    logic [$clog2(debug_cpu_pkg::CLKS_PER_BIT)-1:0] tick_cnt;

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            shift    <= '1;
            busy     <= 1'b0;
            bit_cnt  <= '0;
            tick_cnt <= '0;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (!busy) begin
                if (i_start) begin
                    shift    <= {1'b1, i_data, 1'b0};
                    busy     <= 1'b1;
                    bit_cnt  <= '0;
                    tick_cnt <= '0;
                end
            end else if (tick_cnt == debug_cpu_pkg::CLKS_PER_BIT - 1) begin
                tick_cnt <= '0;
                shift    <= {1'b1, shift[debug_cpu_pkg::BYTE_W+1:1]};  // Refill with idle
                if (bit_cnt == debug_cpu_pkg::BYTE_W + 1) begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    assign o_tx = shift[0];

endmodule

`default_nettype wire

// ==== verification/debug_cpu_properties.sv ====
`default_nettype none

module debug_cpu_properties (
    input wire                              i_clock,
    input wire                              i_rst,
    input wire                              i_tx,
    input wire                              i_busy,
    input wire                              i_halted,
    input wire [debug_cpu_pkg::WORD_W-1:0]  i_pc
);

    timeunit 1ns;
    timeprecision 100ps;

    // Serial line idles between commands
    tx_idle: assert property (@(posedge i_clock) disable iff (i_rst) !i_busy |-> i_tx)
        else $error("o_tx is low while o_busy is low");

    halt_sticky: assert property (@(posedge i_clock) disable iff (i_rst) i_halted |=> i_halted)
        else $error("o_halted fell without a reset");

    pc_frozen: assert property (@(posedge i_clock) disable iff (i_rst)
                                i_halted |=> $stable(i_pc))
        else $error("PC moved while the core is halted");

endmodule

bind debug_cpu_top debug_cpu_properties debug_cpu_properties_1 (
    .i_clock(i_clock), .i_rst(i_rst), .i_tx(o_tx), .i_busy(o_busy),
    .i_halted(o_halted), .i_pc(pc));

`default_nettype wire

// ==== verification/debug_cpu_tb.sv ====
`default_nettype none

module debug_cpu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic clock = 1'b0;
    logic rst;
    logic rx;
    logic tx;
    logic halted;
    logic busy;

    logic [debug_cpu_pkg::BYTE_W-1:0] rx_bytes [$];   // Bytes seen on o_tx
    debug_cpu_pkg::instr_t            prog [debug_cpu_pkg::MEM_WORDS];
    logic [debug_cpu_pkg::WORD_W-1:0] model_regs [debug_cpu_pkg::NUM_REGS];
    logic [debug_cpu_pkg::WORD_W-1:0] model_dmem [debug_cpu_pkg::MEM_WORDS];
    logic [debug_cpu_pkg::WORD_W-1:0] model_pc;
    logic                             model_halted;
    logic [debug_cpu_pkg::WORD_W-1:0] dump_words [debug_cpu_pkg::NUM_REGS];
    int                               errors;
    int                               timeouts;

    debug_cpu_top UUT (.i_clock(clock), .i_rst(rst), .i_rx(rx), .o_tx(tx),
                       .o_halted(halted), .o_busy(busy));

    always #4 clock = ~clock;

    // Mid-bit sampler for frames leaving the DUT
    always begin : frame_monitor
        logic [debug_cpu_pkg::BYTE_W-1:0] data;
        @(negedge clock);
        if (tx === 1'b0) begin
            repeat (debug_cpu_pkg::CLKS_PER_BIT / 2 - 1) @(negedge clock);
            for (int b = 0; b < debug_cpu_pkg::BYTE_W; b++) begin
                repeat (debug_cpu_pkg::CLKS_PER_BIT) @(negedge clock);
                data[b] = tx;
            end
            repeat (debug_cpu_pkg::CLKS_PER_BIT) @(negedge clock);
            if (tx !== 1'b1) begin
                $display("A serial frame from the DUT has a bad stop bit");
                errors++;
            end
            rx_bytes.push_back(data);
        end
    end

    task automatic send_byte(input logic [debug_cpu_pkg::BYTE_W-1:0] b);
        logic [debug_cpu_pkg::BYTE_W+1:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int k = 0; k < debug_cpu_pkg::BYTE_W + 2; k++) begin
            @(negedge clock);
            rx = frame[k];
            repeat (debug_cpu_pkg::CLKS_PER_BIT - 1) @(negedge clock);
        end
    endtask

    task automatic check_word(input string name, input logic [debug_cpu_pkg::WORD_W-1:0] exp,
                              input logic [debug_cpu_pkg::WORD_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_instr(input string name, input debug_cpu_pkg::instr_t exp,
                               input debug_cpu_pkg::instr_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    function automatic debug_cpu_pkg::instr_t make_rtype(input logic [3:0] op,
            input logic [2:0] rd, input logic [2:0] rs, input logic [2:0] rt);
        debug_cpu_pkg::instr_t ins;
        ins = '0;
        ins.r.opcode = op;
        ins.r.rd = rd;
        ins.r.rs = rs;
        ins.r.rt = rt;
        return ins;
    endfunction

    function automatic debug_cpu_pkg::instr_t make_itype(input logic [3:0] op,
            input logic [2:0] rt, input logic [2:0] rs, input logic [15:0] imm);
        debug_cpu_pkg::instr_t ins;
        ins = '0;
        ins.i.opcode = op;
        ins.i.rt = rt;
        ins.i.rs = rs;
        ins.i.imm = imm;
        return ins;
    endfunction

    // Data memory of the model keeps its contents over a reset
    task automatic model_reset();
        model_pc = '0;
        model_halted = 1'b0;
        for (int k = 0; k < debug_cpu_pkg::NUM_REGS; k++) begin
            model_regs[k] = '0;
        end
    endtask

    task automatic set_model_reg(input logic [2:0] idx, input logic [31:0] val);
        if (idx != 0) model_regs[idx] = val;   // r0 stays zero
    endtask

    task automatic model_step();
        debug_cpu_pkg::instr_t ins;
        int                    imm;
        logic [31:0]           sum;
        if (model_halted) return;
        ins = prog[model_pc % debug_cpu_pkg::MEM_WORDS];
        imm = $signed(ins.i.imm);
        sum = model_regs[ins.i.rs] + imm;
        case (ins.r.opcode)
            debug_cpu_pkg::OP_ADD:
                set_model_reg(ins.r.rd, model_regs[ins.r.rs] + model_regs[ins.r.rt]);
            debug_cpu_pkg::OP_SUB:
                set_model_reg(ins.r.rd, model_regs[ins.r.rs] - model_regs[ins.r.rt]);
            debug_cpu_pkg::OP_ADDI: set_model_reg(ins.i.rt, sum);
            debug_cpu_pkg::OP_LW:   set_model_reg(ins.i.rt, model_dmem[sum % 16]);
            debug_cpu_pkg::OP_SW:   model_dmem[sum % 16] = model_regs[ins.i.rt];
            default:                model_halted = 1'b1;
        endcase
        if (!model_halted) model_pc = model_pc + 1;
    endtask

    task automatic model_run();
        for (int k = 0; k < 64 && !model_halted; k++) begin
            model_step();
        end
    endtask

    task automatic apply_reset();
        @(negedge clock);
        rst = 1'b1;
        repeat (3) @(negedge clock);
        rst = 1'b0;
        rx_bytes.delete();
        model_reset();
    endtask

    task automatic write_instr(input logic [3:0] addr, input debug_cpu_pkg::instr_t w);
        debug_cpu_pkg::instr_t readback;
        int                    cnt;
        send_byte(debug_cpu_pkg::CMD_WRITE);
        send_byte({4'h0, addr});
        for (int k = 0; k < 4; k++) begin
            send_byte(w[8*k +: 8]);   // LSB first
        end
        cnt = 0;
        while (busy && cnt < 1000) begin
            @(negedge clock);
            cnt++;
        end
        if (busy) begin
            $display("Timeout: the debug unit stayed busy after a write command");
            timeouts++;
        end
        readback = UUT.instr_mem_1.mem[addr];
        check_instr($sformatf("write %0d", addr), w, readback);
        prog[addr] = w;
    endtask

    // Sends a command, waits for the 32 byte dump and checks it against the model
    task automatic issue_command(input string name, input logic [7:0] cmd);
        int cnt;
        send_byte(cmd);
        cnt = 0;
        while (!(rx_bytes.size() >= 4 * debug_cpu_pkg::NUM_REGS && !busy) && cnt < 20000) begin
            @(negedge clock);
            cnt++;
        end
        if (cnt >= 20000) begin
            $display("Timeout in %s: the register dump did not complete", name);
            timeouts++;
            return;
        end
        for (int w = 0; w < debug_cpu_pkg::NUM_REGS; w++) begin
            for (int b = 0; b < 4; b++) begin
                dump_words[w][8*b +: 8] = rx_bytes.pop_front();
            end
        end
        check_word({name, " pc"}, model_pc, dump_words[0]);
        for (int r = 1; r < debug_cpu_pkg::NUM_REGS; r++) begin
            check_word($sformatf("%s r%0d", name, r), model_regs[r], dump_words[r]);
        end
        check_word({name, " extra bytes"}, 0, rx_bytes.size());
    endtask

    task automatic test_reset();
        apply_reset();
        check_bit("reset o_tx", 1'b1, tx);
        check_bit("reset o_halted", 1'b0, halted);
        check_bit("reset o_busy", 1'b0, busy);
    endtask

    task automatic test_step();
        write_instr(4'd0, make_itype(debug_cpu_pkg::OP_ADDI, 3'd1, 3'd0, 16'd5));
        write_instr(4'd1, make_itype(debug_cpu_pkg::OP_ADDI, 3'd2, 3'd1, 16'hfffd));
        write_instr(4'd2, make_rtype(debug_cpu_pkg::OP_ADD, 3'd3, 3'd1, 3'd2));
        write_instr(4'd3, make_rtype(debug_cpu_pkg::OP_SUB, 3'd4, 3'd2, 3'd1));
        write_instr(4'd4, make_itype(debug_cpu_pkg::OP_ADDI, 3'd5, 3'd4, 16'd100));
        write_instr(4'd5, make_rtype(debug_cpu_pkg::OP_HALT, 3'd0, 3'd0, 3'd0));
        model_step();
        issue_command("step", debug_cpu_pkg::CMD_STEP);
    endtask

    task automatic test_run();
        model_run();
        issue_command("run", debug_cpu_pkg::CMD_RUN);
        check_bit("run o_halted", 1'b1, halted);
    endtask

    task automatic test_load_store();
        apply_reset();
        write_instr(4'd0, make_itype(debug_cpu_pkg::OP_ADDI, 3'd1, 3'd0, 16'h1234));
        write_instr(4'd1, make_itype(debug_cpu_pkg::OP_ADDI, 3'd2, 3'd0, 16'd18));
        write_instr(4'd2, make_itype(debug_cpu_pkg::OP_SW, 3'd1, 3'd2, 16'hffff));  // Index 17 wraps
        write_instr(4'd3, make_itype(debug_cpu_pkg::OP_LW, 3'd6, 3'd2, 16'hffff));
        write_instr(4'd4, make_itype(debug_cpu_pkg::OP_ADDI, 3'd7, 3'd6, 16'd1));
        write_instr(4'd5, make_rtype(debug_cpu_pkg::OP_HALT, 3'd0, 3'd0, 3'd0));
        model_run();
        issue_command("load_store", debug_cpu_pkg::CMD_RUN);
        check_word("load_store r6", 32'h0000_1234, dump_words[6]);
    endtask

    task automatic test_step_halted();
        model_step();
        issue_command("step_halted", debug_cpu_pkg::CMD_STEP);
        check_bit("step_halted o_halted", 1'b1, halted);
    endtask

    task automatic test_unknown_cmd();
        logic busy_seen;
        apply_reset();
        busy_seen = 1'b0;
        // Watch o_busy from the start bit on
        fork
            send_byte(8'h41);
            for (int k = 0; k < 50 * debug_cpu_pkg::CLKS_PER_BIT; k++) begin
                @(negedge clock);
                if (busy) busy_seen = 1'b1;
            end
        join
        check_bit("unknown o_busy", 1'b0, busy_seen);
        check_word("unknown dump bytes", 0, rx_bytes.size());
        model_step();
        issue_command("unknown then step", debug_cpu_pkg::CMD_STEP);
    endtask

    initial begin
        errors = 0;
        timeouts = 0;
        rst = 1'b1;
        rx = 1'b1;
        test_reset();
        test_step();
        test_run();
        test_load_store();
        test_step_halted();
        test_unknown_cmd();
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
